/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_merge_top
FLIST     = flist.f
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* design/head_stage.sv */
`timescale 1ns/1ps

module head_stage (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  logic              i_fifo_valid,   // Input FIFO has a word
   input  merge_pkg::key_t   i_fifo_key,     // Show-ahead FIFO data
   output logic              o_fifo_rd,      // Take the FIFO word this cycle
   input  logic              i_pop,          // Control consumes the head
   output merge_pkg::head_t  o_head          // Current head of the stream
);

   merge_pkg::head_t head_q;                 // Head register
   logic             slot_free;              // Register empty or leaving now
   logic             load;                   // New key enters the register
   logic             key_zero;               // Incoming word is a delimiter

   // Popping a head frees the slot in the same cycle, so refills back to back
   assign slot_free = !head_q.valid || i_pop;
   assign load      = slot_free && i_fifo_valid;
   assign o_fifo_rd = load;

   // Delimiter decode done once here, control only sees the flag
   assign key_zero = (i_fifo_key == '0);

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         head_q.valid <= 1'b0;               // Key and flag are payload
      end else begin
         if (load) begin
            head_q.key   <= i_fifo_key;
            head_q.delim <= key_zero;
            head_q.valid <= 1'b1;
         end else if (i_pop) begin
            head_q.valid <= 1'b0;            // Popped with nothing to refill
         end
      end
   end

   assign o_head = head_q;

endmodule

/* design/merge_control.sv */
`timescale 1ns/1ps

module merge_control (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  merge_pkg::head_t  i_head_a,       // Head of stream A
   input  merge_pkg::head_t  i_head_b,       // Head of stream B
   input  logic              i_emit_ready,   // Emit stage takes o_emit
   output logic              o_pop_a,        // Consume head A
   output logic              o_pop_b,        // Consume head B
   output merge_pkg::emit_t  o_emit          // Registered output word
);

   merge_pkg::merge_state_e state;
   merge_pkg::merge_state_e next_state;
   merge_pkg::emit_t        emit_d;          // Word chosen this cycle
   logic                    advance;         // Output register can take a word
   logic                    a_wins;          // A key not above B key

   // Output register frees when empty or when its word is taken
   assign advance = !o_emit.valid || i_emit_ready;

   // Ties go to A, keeps the merge stable
   assign a_wins = (i_head_a.key <= i_head_b.key);

   always_comb begin
      next_state   = state;
      o_pop_a      = 1'b0;
      o_pop_b      = 1'b0;
      emit_d.key   = a_wins ? i_head_a.key : i_head_b.key;
      emit_d.valid = 1'b0;
      emit_d.last  = 1'b0;
      if (advance) begin                     // Stall everything on back-pressure
         case (state)
            merge_pkg::NOMINAL: begin
               if (i_head_a.valid && i_head_b.valid) begin   // Need both heads
                  if (i_head_a.delim) begin
                     next_state = merge_pkg::DONE_A;         // A run over
                  end else if (i_head_b.delim) begin
                     next_state = merge_pkg::DONE_B;         // B run over
                  end else begin
                     emit_d.valid = 1'b1;                    // Smaller key out
                     o_pop_a      = a_wins;
                     o_pop_b      = !a_wins;
                  end
               end
            end
            merge_pkg::DONE_A: begin
               if (i_head_b.valid) begin
                  if (i_head_b.delim) begin
                     next_state = merge_pkg::TOGGLE;         // B drained too
                  end else begin
                     emit_d.key   = i_head_b.key;
                     emit_d.valid = 1'b1;
                     o_pop_b      = 1'b1;
                  end
               end
            end
            merge_pkg::DONE_B: begin
               if (i_head_a.valid) begin
                  if (i_head_a.delim) begin
                     next_state = merge_pkg::TOGGLE;         // A drained too
                  end else begin
                     emit_d.key   = i_head_a.key;
                     emit_d.valid = 1'b1;
                     o_pop_a      = 1'b1;
                  end
               end
            end
            merge_pkg::TOGGLE: begin
               // Both heads sit on their delimiters here
               if (i_head_a.valid && i_head_b.valid) begin
                  emit_d.key   = '0;                         // Single delimiter out
                  emit_d.valid = 1'b1;
                  emit_d.last  = 1'b1;
                  o_pop_a      = 1'b1;
                  o_pop_b      = 1'b1;
                  next_state   = merge_pkg::NOMINAL;         // Next run pair
               end
            end
            default: next_state = merge_pkg::NOMINAL;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state        <= merge_pkg::NOMINAL;
         o_emit.valid <= 1'b0;
      end else begin
         state <= next_state;
         if (advance) begin
            o_emit <= emit_d;                // Bubble loads when nothing chosen
         end
      end
   end

endmodule

/* design/merge_emit.sv */
`timescale 1ns/1ps

module merge_emit (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  merge_pkg::emit_t  i_emit,         // Word from control
   output logic              o_emit_ready,   // Register can take i_emit
   output logic              o_wr_valid,     // Write request to output FIFO
   output merge_pkg::key_t   o_wr_key,
   input  logic              i_wr_ready,     // Output FIFO has room
   output logic [15:0]       o_run_count     // Merged runs written out
);

   merge_pkg::emit_t emit_q;                 // One-entry pipeline register
   logic             wr_fire;                // Word leaves to the FIFO

   assign o_wr_valid = emit_q.valid;
   assign o_wr_key   = emit_q.key;
   assign wr_fire    = emit_q.valid && i_wr_ready;

   // Take a new word when empty or when the held word leaves now
   assign o_emit_ready = !emit_q.valid || i_wr_ready;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         emit_q.valid <= 1'b0;
         o_run_count  <= '0;
      end else begin
         if (o_emit_ready) begin
            emit_q <= i_emit;
         end
         if (wr_fire && emit_q.last) begin
            o_run_count <= o_run_count + 16'd1;   // Delimiter closes a run
         end
      end
   end

endmodule

/* design/merge_pkg.sv */
`include "merge_settings.svh"

package merge_pkg;

   typedef logic [`MERGE_KEY_W-1:0] key_t;   // One key, zero marks end of run

   // Current head of one input stream
   typedef struct packed {
      key_t key;                              // Head key
      logic valid;                            // Head register is full
      logic delim;                            // Key is the run delimiter
   } head_t;

   // Word handed from the control FSM to the emit stage
   typedef struct packed {
      key_t key;                              // Key to emit
      logic valid;                            // Word present
      logic last;                             // Delimiter closing the merged run
   } emit_t;

   typedef enum logic [1:0] {
      NOMINAL,                                // Compare heads, emit smaller
      DONE_A,                                 // A run ended, drain B
      DONE_B,                                 // B run ended, drain A
      TOGGLE                                  // Both at delimiter, close run
   } merge_state_e;

endpackage

/* design/merge_settings.svh */
`ifndef MERGE_SETTINGS_SVH
`define MERGE_SETTINGS_SVH

// Key width in bits, zero is reserved for the run delimiter
`define MERGE_KEY_W 16

// Input FIFOs absorb source bursts and gaps
`define MERGE_IN_DEPTH_LOG2 3

// Output FIFO only needs to cover the emit register round trip
`define MERGE_OUT_DEPTH_LOG2 2

`endif

/* design/merge_top.sv */
`timescale 1ns/1ps
`include "merge_settings.svh"

module merge_top (
   input  logic             i_clk,
   input  logic             i_rst_n,
   input  logic             i_a_valid,       // Stream A
   input  merge_pkg::key_t  i_a_key,
   output logic             o_a_ready,
   input  logic             i_b_valid,       // Stream B
   input  merge_pkg::key_t  i_b_key,
   output logic             o_b_ready,
   output logic             o_m_valid,       // Merged stream
   output merge_pkg::key_t  o_m_key,
   input  logic             i_m_ready,
   output logic [15:0]      o_run_count      // Runs merged so far
);

   logic             a_rd_valid;             // FIFO A to head A
   merge_pkg::key_t  a_rd_key;
   logic             a_rd_en;
   logic             b_rd_valid;             // FIFO B to head B
   merge_pkg::key_t  b_rd_key;
   logic             b_rd_en;
   merge_pkg::head_t a_head;
   merge_pkg::head_t b_head;
   logic             pop_a;
   logic             pop_b;
   merge_pkg::emit_t emit_word;              // Control to emit stage
   logic             emit_ready;
   logic             m_wr_valid;             // Emit stage to output FIFO
   merge_pkg::key_t  m_wr_key;
   logic             m_wr_ready;

   run_fifo #(.DEPTH_LOG2(`MERGE_IN_DEPTH_LOG2)) fifo_a (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_wr_valid(i_a_valid), .i_wr_key(i_a_key), .o_wr_ready(o_a_ready),
      .o_rd_valid(a_rd_valid), .o_rd_key(a_rd_key), .i_rd_en(a_rd_en)
   );

   run_fifo #(.DEPTH_LOG2(`MERGE_IN_DEPTH_LOG2)) fifo_b (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_wr_valid(i_b_valid), .i_wr_key(i_b_key), .o_wr_ready(o_b_ready),
      .o_rd_valid(b_rd_valid), .o_rd_key(b_rd_key), .i_rd_en(b_rd_en)
   );

   head_stage head_a (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_fifo_valid(a_rd_valid),
      .i_fifo_key(a_rd_key), .o_fifo_rd(a_rd_en), .i_pop(pop_a), .o_head(a_head)
   );

   head_stage head_b (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_fifo_valid(b_rd_valid),
      .i_fifo_key(b_rd_key), .o_fifo_rd(b_rd_en), .i_pop(pop_b), .o_head(b_head)
   );

   merge_control control (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_head_a(a_head), .i_head_b(b_head),
      .i_emit_ready(emit_ready), .o_pop_a(pop_a), .o_pop_b(pop_b), .o_emit(emit_word)
   );

   merge_emit emit (
      .i_clk(i_clk), .i_rst_n(i_rst_n), .i_emit(emit_word), .o_emit_ready(emit_ready),
      .o_wr_valid(m_wr_valid), .o_wr_key(m_wr_key), .i_wr_ready(m_wr_ready),
      .o_run_count(o_run_count)
   );

   run_fifo #(.DEPTH_LOG2(`MERGE_OUT_DEPTH_LOG2)) fifo_m (
      .i_clk(i_clk), .i_rst_n(i_rst_n),
      .i_wr_valid(m_wr_valid), .i_wr_key(m_wr_key), .o_wr_ready(m_wr_ready),
      .o_rd_valid(o_m_valid), .o_rd_key(o_m_key), .i_rd_en(i_m_ready)
   );

endmodule

/* design/run_fifo.sv */
`timescale 1ns/1ps

module run_fifo #(
   parameter int DEPTH_LOG2 = 3
) (
   input  logic             i_clk,
   input  logic             i_rst_n,
   input  logic             i_wr_valid,
   input  merge_pkg::key_t  i_wr_key,
   output logic             o_wr_ready,
   output logic             o_rd_valid,
   output merge_pkg::key_t  o_rd_key,
   input  logic             i_rd_en
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   merge_pkg::key_t       mem [0:DEPTH-1];   // Storage, no reset needed
   logic [DEPTH_LOG2:0]   wr_ptr;            // MSB is the wrap bit
   logic [DEPTH_LOG2:0]   rd_ptr;            // MSB is the wrap bit
   logic                  empty;
   logic                  full;
   logic                  wr_fire;           // Word accepted this cycle
   logic                  rd_fire;           // Word consumed this cycle

   // Same index and same wrap means empty, opposite wrap means full
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                  (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

   assign rd_fire = i_rd_en && !empty;       // Ignore reads of an empty FIFO

   // A slot frees up when a read happens in the same cycle as a full write
   assign o_wr_ready = !full || rd_fire;
   assign wr_fire    = i_wr_valid && o_wr_ready;

   // Show-ahead read side, data visible the cycle after the write
   assign o_rd_valid = !empty;
   assign o_rd_key   = mem[rd_ptr[DEPTH_LOG2-1:0]];

   always_ff @(posedge i_clk) begin
      if (wr_fire) begin
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_wr_key;   // Payload write
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_fire) begin
            wr_ptr <= wr_ptr + 1'b1;         // Wraps into the MSB
         end
         if (rd_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

endmodule

/* flist.f */
+incdir+design
design/merge_pkg.sv
design/run_fifo.sv
design/head_stage.sv
design/merge_control.sv
design/merge_emit.sv
design/merge_top.sv
testbench/tb_clock_gen.sv
testbench/merge_assertions.sv
testbench/tb_merge_top.sv

/* testbench/merge_assertions.sv */
`timescale 1ns/1ps

module merge_assertions (
   input logic                    i_clk,
   input logic                    i_rst_n,
   input logic                    i_m_valid,  // Output FIFO has a word
   input merge_pkg::key_t         i_m_key,
   input logic                    i_m_ready,  // Sink takes the word
   input merge_pkg::merge_state_e i_state     // Control FSM state
);

   merge_pkg::key_t prev_key;                 // Last key taken from the run
   logic            in_run;                   // A key of this run already left

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         in_run <= 1'b0;
      end else if (i_m_valid && i_m_ready) begin
         in_run   <= (i_m_key != '0);         // Delimiter opens a new run
         prev_key <= i_m_key;
      end
   end

   // Word held steady while the sink stalls
   m_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_m_valid && !i_m_ready |=> i_m_valid && $stable(i_m_key))
      else $error("Output word dropped or changed while waiting for i_m_ready");

   m_reset_quiet: assert property (@(posedge i_clk)
      !i_rst_n |=> !i_m_valid && (i_state == merge_pkg::NOMINAL))
      else $error("Output active or FSM not idle after a reset cycle");

   m_order: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_m_valid && i_m_ready && (i_m_key != '0) && in_run |-> i_m_key >= prev_key)
      else $error("Merged run went down from one key to the next");

endmodule

bind merge_top merge_assertions assertions_inst (
   .i_clk(i_clk), .i_rst_n(i_rst_n), .i_m_valid(o_m_valid), .i_m_key(o_m_key),
   .i_m_ready(i_m_ready), .i_state(control.state)
);

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter real PERIOD_NS = 8.0              // Clock period in ns
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0) o_clk = ~o_clk;   // Half period per toggle
      end
   end

endmodule

/* testbench/tb_merge_top.sv */
`timescale 1ns/1ps

module tb_merge_top;

   logic            clk;
   logic            rst_n;
   logic            a_valid;
   merge_pkg::key_t a_key;
   logic            a_ready;
   logic            b_valid;
   merge_pkg::key_t b_key;
   logic            b_ready;
   logic            m_valid;
   merge_pkg::key_t m_key;
   logic            m_ready;
   logic [15:0]     run_count;

   merge_pkg::key_t a_q[$];                   // Words still to send on A
   merge_pkg::key_t b_q[$];                   // Words still to send on B
   merge_pkg::key_t exp_q[$];                 // Model output in order
   logic [31:0]     lfsr_state [0:3];         // Data, A gaps, B gaps, M ready
   logic            gaps_on;                  // Random idle cycles on A and B
   logic            throttle_on;              // Random stalls on M
   int              pair_count;
   int              test_count;
   int              check_count;
   int              error_count;
   int              cycle_count;
   int              test_start;               // Cycle the current test began
   int              cycle_limit;

   tb_clock_gen clock_gen (.o_clk(clk));

   merge_top UUT (
      .i_clk(clk), .i_rst_n(rst_n),
      .i_a_valid(a_valid), .i_a_key(a_key), .o_a_ready(a_ready),
      .i_b_valid(b_valid), .i_b_key(b_key), .o_b_ready(b_ready),
      .o_m_valid(m_valid), .o_m_key(m_key), .i_m_ready(m_ready),
      .o_run_count(run_count)
   );

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] rand_bits(int ch, int n);
      logic [31:0] s;
      logic [31:0] r;
      logic        fb;
      int          k;
      s = lfsr_state[ch];
      r = '0;
      for (k = 0; k < n; k++) begin
         fb = s[31] ^ s[21] ^ s[1] ^ s[0];
         s  = {s[30:0], fb};
         r  = {r[30:0], fb};
      end
      lfsr_state[ch] = s;
      return r;
   endfunction

   task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t",
                  name, actual, expected, $time);
      end
   endtask

   // Two sorted runs and the reference merge with ties to A
   function automatic void add_pair(int len_a, int len_b, int step_bits);
      merge_pkg::key_t run_a[$];
      merge_pkg::key_t run_b[$];
      merge_pkg::key_t key;
      int              i;
      int              j;
      key = merge_pkg::key_t'(1);
      for (i = 0; i < len_a; i++) begin
         key = key + merge_pkg::key_t'(rand_bits(0, step_bits));   // Never below last
         run_a.push_back(key);
      end
      key = merge_pkg::key_t'(1);
      for (j = 0; j < len_b; j++) begin
         key = key + merge_pkg::key_t'(rand_bits(0, step_bits));
         run_b.push_back(key);
      end
      i = 0;
      j = 0;
      while (i < run_a.size() || j < run_b.size()) begin
         if (j == run_b.size() || (i < run_a.size() && run_a[i] <= run_b[j])) begin
            exp_q.push_back(run_a[i]);
            i++;
         end else begin
            exp_q.push_back(run_b[j]);
            j++;
         end
      end
      exp_q.push_back('0);                    // One delimiter per pair
      for (i = 0; i < run_a.size(); i++) begin
         a_q.push_back(run_a[i]);
      end
      for (j = 0; j < run_b.size(); j++) begin
         b_q.push_back(run_b[j]);
      end
      a_q.push_back('0);
      b_q.push_back('0);
      pair_count++;
   endfunction

   task automatic apply_reset();
      @(posedge clk);
      rst_n   <= 1'b0;
      a_valid <= 1'b0;
      b_valid <= 1'b0;
      m_ready <= 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   // Ready is sampled on the falling edge and the transfer lands on the next rising edge
   task automatic drive_a();
      while (a_q.size() > 0) begin
         @(posedge clk);
         if (gaps_on && rand_bits(1, 2) == 32'd0) begin
            a_valid <= 1'b0;                  // Idle cycle
         end else begin
            a_valid <= 1'b1;
            a_key   <= a_q.pop_front();
            @(negedge clk);
            while (!a_ready) begin
               @(posedge clk);
               @(negedge clk);
            end
         end
      end
      @(posedge clk);
      a_valid <= 1'b0;
   endtask

   task automatic drive_b();
      while (b_q.size() > 0) begin
         @(posedge clk);
         if (gaps_on && rand_bits(2, 2) == 32'd0) begin
            b_valid <= 1'b0;
         end else begin
            b_valid <= 1'b1;
            b_key   <= b_q.pop_front();
            @(negedge clk);
            while (!b_ready) begin
               @(posedge clk);
               @(negedge clk);
            end
         end
      end
      @(posedge clk);
      b_valid <= 1'b0;
   endtask

   task automatic collect();
      while (exp_q.size() > 0) begin
         @(posedge clk);
         m_ready <= throttle_on ? (rand_bits(3, 1) != 32'd0) : 1'b1;
         @(negedge clk);
         if (m_valid && m_ready) begin
            check_value("o_m_key", 32'(m_key), 32'(exp_q.pop_front()));
         end
      end
      @(posedge clk);
      m_ready <= 1'b0;                        // Extra words stay visible
   endtask

   task automatic run_traffic(string name);
      int errors_before;
      errors_before = error_count;
      apply_reset();
      test_start  = cycle_count;
      cycle_limit = 40 * (a_q.size() + b_q.size()) + 200;
      fork
         drive_a();
         drive_b();
         collect();
      join
      repeat (8) @(posedge clk);
      @(negedge clk);
      check_value("o_m_valid", 32'(m_valid), 32'd0);
      check_value("o_run_count", 32'(run_count), pair_count);
      test_count++;
      $display("Test %0d %s: %0d run pairs, %0d mismatches", test_count, name,
               pair_count, error_count - errors_before);
      pair_count = 0;
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count - test_start > cycle_limit) begin
         $display("Timeout: test %0d made no progress within %0d cycles",
                  test_count + 1, cycle_limit);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      rst_n       <= 1'b0;
      a_valid     <= 1'b0;
      a_key       <= '0;
      b_valid     <= 1'b0;
      b_key       <= '0;
      m_ready     <= 1'b0;
      cycle_count <= 0;
      gaps_on     = 1'b0;
      throttle_on = 1'b0;
      pair_count  = 0;
      test_count  = 0;
      check_count = 0;
      error_count = 0;
      test_start  = 0;
      cycle_limit = 400;
      lfsr_state[0] = 32'hc348;
      lfsr_state[1] = rand_bits(0, 32);       // Other channels seeded from data
      lfsr_state[2] = rand_bits(0, 32);
      lfsr_state[3] = rand_bits(0, 32);

      add_pair(int'(rand_bits(0, 3)) + 1, int'(rand_bits(0, 3)) + 1, 8);
      run_traffic("single run pair");

      repeat (20) add_pair(int'(rand_bits(0, 3)) + 1, int'(rand_bits(0, 3)) + 1, 8);
      run_traffic("twenty run pairs");

      add_pair(0, int'(rand_bits(0, 3)) + 1, 8);   // Lone delimiter on A
      add_pair(int'(rand_bits(0, 3)) + 1, 0, 8);   // Lone delimiter on B
      add_pair(0, 0, 8);
      run_traffic("empty runs");

      repeat (6) add_pair(int'(rand_bits(0, 3)) + 1, int'(rand_bits(0, 3)) + 1, 1);
      run_traffic("equal keys");

      throttle_on = 1'b1;
      repeat (8) add_pair(int'(rand_bits(0, 3)) + 1, int'(rand_bits(0, 3)) + 1, 8);
      run_traffic("output back-pressure");
      throttle_on = 1'b0;

      gaps_on = 1'b1;
      repeat (8) add_pair(int'(rand_bits(0, 3)) + 1, int'(rand_bits(0, 3)) + 1, 8);
      run_traffic("input valid gaps");
      gaps_on = 1'b0;

      $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
